// File: logic/isa_pkg.sv
package isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;  // Data word
    typedef logic [31:0]     inst_t;  // Raw instruction word

    // Poison values so a bad select is easy to spot in waves
    localparam xlen_t OPA_POISON = 32'hdeadfbac;
    localparam xlen_t OPB_POISON = 32'hfacefeed;
    localparam xlen_t ALU_POISON = 32'hfacebeec;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_SLT    = 4'h2,
        ALU_SLTU   = 4'h3,
        ALU_AND    = 4'h4,
        ALU_OR     = 4'h5,
        ALU_XOR    = 4'h6,
        ALU_SLL    = 4'h7,
        ALU_SRL    = 4'h8,
        ALU_SRA    = 4'h9,
        ALU_MUL    = 4'ha,
        ALU_MULH   = 4'hb,
        ALU_MULHSU = 4'hc,
        ALU_MULHU  = 4'hd
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,  // pc + 4, link value
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_sel_e;

    // Codes 6 and 7 are unused
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

endpackage

// File: logic/ooo_pkg.sv
package ooo_pkg;

    // ROB entry index width, 32 entries
    localparam int ROB_TAG_W = 5;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Access size as encoded in funct3 of loads and stores
    // Bit 2 set means zero extension on loads
    typedef logic [2:0] mem_size_t;

endpackage

// File: logic/issue_if.sv
`timescale 1ns/1ps

interface issue_if import isa_pkg::*, ooo_pkg::*; ();

    logic      valid;          // Single cycle strobe
    inst_t     inst;
    xlen_t     pc;
    opa_sel_e  opa_sel;
    opb_sel_e  opb_sel;
    alu_func_e func;
    logic      cond_branch;
    logic      uncond_branch;
    logic      rd_mem;         // Load
    logic      wr_mem;         // Store
    xlen_t     rs1_value;
    xlen_t     rs2_value;
    rob_tag_t  rd_tag;

    modport issuer (
        output valid, inst, pc, opa_sel, opb_sel, func,
        output cond_branch, uncond_branch, rd_mem, wr_mem,
        output rs1_value, rs2_value, rd_tag
    );

    modport unit (
        input valid, inst, pc, opa_sel, opb_sel, func,
        input cond_branch, uncond_branch, rd_mem, wr_mem,
        input rs1_value, rs2_value, rd_tag
    );

endinterface

// File: logic/operand_select.sv
`timescale 1ns/1ps

module operand_select import isa_pkg::*; (
    input  inst_t    inst,
    input  xlen_t    pc,
    input  opa_sel_e opa_sel,
    input  opb_sel_e opb_sel,
    input  xlen_t    rs1_value,
    input  xlen_t    rs2_value,
    output xlen_t    opa,
    output xlen_t    opb
);

    xlen_t i_imm;
    xlen_t s_imm;
    xlen_t b_imm;
    xlen_t u_imm;
    xlen_t j_imm;

    // Sign extended immediates, all formats keep the sign in inst[31]
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opa_sel)
            OPA_IS_RS1:  opa = rs1_value;
            OPA_IS_NPC:  opa = pc + 32'd4;
            OPA_IS_PC:   opa = pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = OPA_POISON;
        endcase
    end

    always_comb begin
        case (opb_sel)
            OPB_IS_RS2:   opb = rs2_value;
            OPB_IS_I_IMM: opb = i_imm;
            OPB_IS_S_IMM: opb = s_imm;
            OPB_IS_B_IMM: opb = b_imm;
            OPB_IS_U_IMM: opb = u_imm;
            OPB_IS_J_IMM: opb = j_imm;
            default:      opb = OPB_POISON;  // Unused codes 6 and 7
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import isa_pkg::*; (
    input  xlen_t     opa,
    input  xlen_t     opb,
    input  alu_func_e func,
    output xlen_t     result
);

    logic [2*XLEN-1:0] opa_sext;
    logic [2*XLEN-1:0] opb_sext;
    logic [2*XLEN-1:0] opb_zext;
    logic [2*XLEN-1:0] mul_ss;
    logic [2*XLEN-1:0] mul_su;
    logic [2*XLEN-1:0] mul_uu;
    logic              lt_signed;

    // Widen first, low 64 bits of the product are exact for every sign mix
    assign opa_sext = {{XLEN{opa[XLEN-1]}}, opa};
    assign opb_sext = {{XLEN{opb[XLEN-1]}}, opb};
    assign opb_zext = {{XLEN{1'b0}}, opb};

    assign mul_ss = opa_sext * opb_sext;
    assign mul_su = opa_sext * opb_zext;
    assign mul_uu = {{XLEN{1'b0}}, opa} * opb_zext;

    assign lt_signed = $signed(opa) < $signed(opb);

    always_comb begin
        case (func)
            ALU_ADD:    result = opa + opb;
            ALU_SUB:    result = opa - opb;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, opa < opb};
            ALU_AND:    result = opa & opb;
            ALU_OR:     result = opa | opb;
            ALU_XOR:    result = opa ^ opb;
            ALU_SLL:    result = opa << opb[4:0];
            ALU_SRL:    result = opa >> opb[4:0];
            ALU_SRA:    result = xlen_t'($signed(opa) >>> opb[4:0]);
            ALU_MUL:    result = mul_ss[XLEN-1:0];
            ALU_MULH:   result = mul_ss[2*XLEN-1:XLEN];
            ALU_MULHSU: result = mul_su[2*XLEN-1:XLEN];
            ALU_MULHU:  result = mul_uu[2*XLEN-1:XLEN];
            default:    result = ALU_POISON;
        endcase
    end

endmodule

// File: logic/branch_cond.sv
`timescale 1ns/1ps

module branch_cond import isa_pkg::*; (
    input  xlen_t      rs1,
    input  xlen_t      rs2,
    input  logic [2:0] funct3,
    output logic       cond
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = rs1 == rs2;
    assign lt  = $signed(rs1) < $signed(rs2);
    assign ltu = rs1 < rs2;

    always_comb begin
        case (funct3)
            3'b000:  cond = eq;    // BEQ
            3'b001:  cond = !eq;   // BNE
            3'b100:  cond = lt;    // BLT
            3'b101:  cond = !lt;   // BGE
            3'b110:  cond = ltu;   // BLTU
            3'b111:  cond = !ltu;  // BGEU
            default: cond = 1'b0;
        endcase
    end

endmodule

// File: logic/alu_exec_unit.sv
`timescale 1ns/1ps

module alu_exec_unit import isa_pkg::*, ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    issue_if.unit    issue,
    output logic     cdb_valid,
    output xlen_t    cdb_value,
    output rob_tag_t cdb_tag,
    output logic     branch_taken,
    output xlen_t    branch_target
);

    xlen_t opa;
    xlen_t opb;
    xlen_t result;
    logic  cond;
    logic  accept;
    logic  is_branch;
    logic  take;

    operand_select i_operand_select (
        .inst      (issue.inst),
        .pc        (issue.pc),
        .opa_sel   (issue.opa_sel),
        .opb_sel   (issue.opb_sel),
        .rs1_value (issue.rs1_value),
        .rs2_value (issue.rs2_value),
        .opa       (opa),
        .opb       (opb)
    );

    alu i_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (issue.func),
        .result (result)
    );

    branch_cond i_branch_cond (
        .rs1    (issue.rs1_value),
        .rs2    (issue.rs2_value),
        .funct3 (issue.inst[14:12]),
        .cond   (cond)
    );

    assign accept    = issue.valid && !issue.rd_mem && !issue.wr_mem;
    assign is_branch = issue.cond_branch || issue.uncond_branch;
    // Unconditional, or conditional with the compare true
    assign take      = issue.uncond_branch || (issue.cond_branch && cond);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid    <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            cdb_valid    <= accept && !is_branch;
            branch_taken <= accept && take;  // Not taken gives no pulse
        end
    end

    // Payload holds between results
    always_ff @(posedge clock) begin
        if (accept && !is_branch) begin
            cdb_value <= result;
            cdb_tag   <= issue.rd_tag;
        end
        if (accept && take) begin
            branch_target <= result;  // ALU computes pc + imm for branches
        end
    end

endmodule

// File: logic/agu_unit.sv
`timescale 1ns/1ps

module agu_unit import isa_pkg::*, ooo_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    issue_if.unit     issue,
    output logic      lb_valid,
    output xlen_t     lb_address,
    output rob_tag_t  lb_tag,
    output mem_size_t lb_size,
    output logic      st_valid,
    output xlen_t     st_address,
    output rob_tag_t  st_tag
);

    xlen_t opa;
    xlen_t opb;
    xlen_t address;
    logic  is_load;
    logic  is_store;

    operand_select i_operand_select (
        .inst      (issue.inst),
        .pc        (issue.pc),
        .opa_sel   (issue.opa_sel),
        .opb_sel   (issue.opb_sel),
        .rs1_value (issue.rs1_value),
        .rs2_value (issue.rs2_value),
        .opa       (opa),
        .opb       (opb)
    );

    // Decode sets func to ADD for memory ops, rs1 + offset
    alu i_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (issue.func),
        .result (address)
    );

    assign is_load  = issue.valid && issue.rd_mem;
    assign is_store = issue.valid && issue.wr_mem && !issue.rd_mem;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            lb_valid <= 1'b0;
            st_valid <= 1'b0;
        end else begin
            lb_valid <= is_load;
            st_valid <= is_store;
        end
    end

    always_ff @(posedge clock) begin
        if (is_load) begin
            lb_address <= address;
            lb_tag     <= issue.rd_tag;
            lb_size    <= issue.inst[14:12];  // Width and sign from funct3
        end
        if (is_store) begin
            st_address <= address;
            st_tag     <= issue.rd_tag;
        end
    end

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import isa_pkg::*, ooo_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    input  logic      issue_valid,
    input  inst_t     issue_inst,
    input  xlen_t     issue_pc,
    input  opa_sel_e  issue_opa_sel,
    input  opb_sel_e  issue_opb_sel,
    input  alu_func_e issue_func,
    input  logic      issue_cond_branch,
    input  logic      issue_uncond_branch,
    input  logic      issue_rd_mem,
    input  logic      issue_wr_mem,
    input  xlen_t     issue_rs1_value,
    input  xlen_t     issue_rs2_value,
    input  rob_tag_t  issue_rd_tag,

    output logic      cdb_valid,
    output xlen_t     cdb_value,
    output rob_tag_t  cdb_tag,
    output logic      branch_taken,
    output xlen_t     branch_target,

    output logic      lb_valid,
    output xlen_t     lb_address,
    output rob_tag_t  lb_tag,
    output mem_size_t lb_size,
    output logic      st_valid,
    output xlen_t     st_address,
    output rob_tag_t  st_tag
);

    issue_if issue ();

    // Reservation station side, one issue broadcast to both units
    assign issue.valid         = issue_valid;
    assign issue.inst          = issue_inst;
    assign issue.pc            = issue_pc;
    assign issue.opa_sel       = issue_opa_sel;
    assign issue.opb_sel       = issue_opb_sel;
    assign issue.func          = issue_func;
    assign issue.cond_branch   = issue_cond_branch;
    assign issue.uncond_branch = issue_uncond_branch;
    assign issue.rd_mem        = issue_rd_mem;
    assign issue.wr_mem        = issue_wr_mem;
    assign issue.rs1_value     = issue_rs1_value;
    assign issue.rs2_value     = issue_rs2_value;
    assign issue.rd_tag        = issue_rd_tag;

    alu_exec_unit i_alu_exec_unit (
        .clock         (clock),
        .rst_n         (rst_n),
        .issue         (issue.unit),
        .cdb_valid     (cdb_valid),
        .cdb_value     (cdb_value),
        .cdb_tag       (cdb_tag),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    agu_unit i_agu_unit (
        .clock      (clock),
        .rst_n      (rst_n),
        .issue      (issue.unit),
        .lb_valid   (lb_valid),
        .lb_address (lb_address),
        .lb_tag     (lb_tag),
        .lb_size    (lb_size),
        .st_valid   (st_valid),
        .st_address (st_address),
        .st_tag     (st_tag)
    );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clock
);

    localparam int HALF_PERIOD = 50;  // 100 ns period

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

endmodule

// File: sim/exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb import isa_pkg::*, ooo_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int REPS         = 3;
    localparam int EDGES        = 5;
    localparam xlen_t EDGE_VALUES [EDGES] = '{32'h80000000, 32'hffffffff, 32'h7fffffff,
                                              32'h00000001, 32'h00000000};
    // Issue strobes over all tests
    localparam int NUM_TESTS = 10 * REPS + 4 * (EDGES + 1) * (EDGES + 1) + 8 * REPS
                             + 7 * 4 + REPS + 8 * REPS + 5;

    // Issue kind bits are cond branch, uncond branch, load and store
    localparam logic [3:0] ISSUE_ALU    = 4'b0000;
    localparam logic [3:0] ISSUE_BRANCH = 4'b1000;
    localparam logic [3:0] ISSUE_JAL    = 4'b0100;
    localparam logic [3:0] ISSUE_LOAD   = 4'b0010;
    localparam logic [3:0] ISSUE_STORE  = 4'b0001;

    logic      clock;
    logic      rst_n;
    logic      issue_valid;
    inst_t     issue_inst;
    xlen_t     issue_pc;
    opa_sel_e  issue_opa_sel;
    opb_sel_e  issue_opb_sel;
    alu_func_e issue_func;
    logic      issue_cond_branch, issue_uncond_branch, issue_rd_mem, issue_wr_mem;
    xlen_t     issue_rs1_value, issue_rs2_value;
    rob_tag_t  issue_rd_tag;
    logic      cdb_valid, branch_taken, lb_valid, st_valid;
    xlen_t     cdb_value, branch_target, lb_address, st_address;
    rob_tag_t  cdb_tag, lb_tag, st_tag;
    mem_size_t lb_size;

    logic [3:0]  exp_valid;  // Expected cdb, branch, load, store valids
    xlen_t       exp_value;
    rob_tag_t    exp_tag;
    mem_size_t   exp_size;
    string       exp_what;
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    tb_clock i_clock (.clock(clock));

    exec_stage i_dut (.*);

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return v;
    endfunction

    function automatic xlen_t model_opb(input opb_sel_e sel, input inst_t i, input xlen_t rs2);
        case (sel)
            OPB_IS_RS2:   return rs2;
            OPB_IS_I_IMM: return $signed(i) >>> 20;
            OPB_IS_S_IMM: return $signed({i[31:25], i[11:7], 20'b0}) >>> 20;
            OPB_IS_B_IMM: return $signed({i[31], i[7], i[30:25], i[11:8], 1'b0, 19'b0}) >>> 19;
            OPB_IS_U_IMM: return {i[31:12], 12'b0};
            OPB_IS_J_IMM: return $signed({i[31], i[19:12], i[20], i[30:21], 1'b0, 11'b0}) >>> 11;
            default:      return '0;
        endcase
    endfunction

    function automatic xlen_t model_alu(input alu_func_e f, input xlen_t a, input xlen_t b);
        longint      sa;
        longint      sb;
        longint      ub;
        logic [63:0] uu;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ub = {32'b0, b};
        uu = {32'b0, a} * {32'b0, b};
        case (f)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_SLT:    return {31'b0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};  // Biased compare
            ALU_SLTU:   return {31'b0, a < b};
            ALU_AND:    return a & b;
            ALU_OR:     return a | b;
            ALU_XOR:    return a ^ b;
            ALU_SLL:    return a << b[4:0];
            ALU_SRL:    return a >> b[4:0];
            ALU_SRA:    return (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'h0);
            ALU_MUL:    return xlen_t'(sa * sb);
            ALU_MULH:   return xlen_t'((sa * sb) >>> 32);
            ALU_MULHSU: return xlen_t'((sa * ub) >>> 32);
            ALU_MULHU:  return uu[63:32];
            default:    return '0;
        endcase
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        logic lt;
        lt = (a ^ 32'h80000000) < (b ^ 32'h80000000);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lt;
            3'b101:  return !lt;
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Checks the previous cycle's issue at the falling edge
    task automatic check_pending();
        check_value({exp_what, " valids"}, 32'({cdb_valid, branch_taken, lb_valid, st_valid}),
                    32'(exp_valid));
        if (exp_valid[3]) begin
            check_value({exp_what, " cdb_value"}, cdb_value, exp_value);
            check_value({exp_what, " cdb_tag"}, 32'(cdb_tag), 32'(exp_tag));
        end
        if (exp_valid[2]) begin
            check_value({exp_what, " branch_target"}, branch_target, exp_value);
        end
        if (exp_valid[1]) begin
            check_value({exp_what, " lb_address"}, lb_address, exp_value);
            check_value({exp_what, " lb_tag"}, 32'(lb_tag), 32'(exp_tag));
            check_value({exp_what, " lb_size"}, 32'(lb_size), 32'(exp_size));
        end
        if (exp_valid[0]) begin
            check_value({exp_what, " st_address"}, st_address, exp_value);
            check_value({exp_what, " st_tag"}, 32'(st_tag), 32'(exp_tag));
        end
    endtask

    task automatic step_issue(input string what, input alu_func_e f, input opa_sel_e a_sel,
                              input opb_sel_e b_sel, input inst_t inst, input xlen_t rs1,
                              input xlen_t rs2, input logic [3:0] kind);
        xlen_t opa;
        logic  alu_op;
        @(negedge clock);
        check_pending();
        issue_valid     = 1'b1;
        issue_func      = f;
        issue_opa_sel   = a_sel;
        issue_opb_sel   = b_sel;
        issue_inst      = inst;
        issue_pc        = rand_bits(32) & 32'hfffffffc;
        issue_rs1_value = rs1;
        issue_rs2_value = rs2;
        issue_rd_tag    = rob_tag_t'(rand_bits(ROB_TAG_W));
        {issue_cond_branch, issue_uncond_branch, issue_rd_mem, issue_wr_mem} = kind;
        case (a_sel)
            OPA_IS_RS1: opa = rs1;
            OPA_IS_NPC: opa = issue_pc + 32'd4;
            OPA_IS_PC:  opa = issue_pc;
            default:    opa = '0;
        endcase
        alu_op    = kind[1:0] == 2'b00;
        exp_what  = what;
        exp_value = model_alu(f, opa, model_opb(b_sel, inst, rs2));
        exp_tag   = issue_rd_tag;
        exp_size  = inst[14:12];
        exp_valid = {alu_op && kind[3:2] == 2'b00,
                     alu_op && (kind[2] || (kind[3] && model_branch(inst[14:12], rs1, rs2))),
                     kind[1], kind[0]};
    endtask

    task automatic step_idle();
        @(negedge clock);
        check_pending();
        issue_valid = 1'b0;
        exp_what    = "idle";
        exp_valid   = 4'b0000;
    endtask

    task automatic test_alu_ops();
        for (int f = 0; f < 10; f++) begin
            for (int r = 0; r < REPS; r++) begin
                step_issue($sformatf("alu func %0d", f), alu_func_e'(f), OPA_IS_RS1, OPB_IS_RS2,
                           rand_bits(32), rand_bits(32), rand_bits(32), ISSUE_ALU);
                step_idle();
            end
        end
    endtask

    task automatic test_multiply();
        xlen_t a;
        xlen_t b;
        for (int f = 10; f < 14; f++) begin
            for (int i = 0; i <= EDGES; i++) begin
                for (int j = 0; j <= EDGES; j++) begin
                    a = i < EDGES ? EDGE_VALUES[i] : rand_bits(32);  // Last index random
                    b = j < EDGES ? EDGE_VALUES[j] : rand_bits(32);
                    step_issue($sformatf("mul func %0d pair %0d/%0d", f, i, j), alu_func_e'(f),
                               OPA_IS_RS1, OPB_IS_RS2, rand_bits(32), a, b, ISSUE_ALU);
                    step_idle();
                end
            end
        end
    endtask

    task automatic test_operand_select();
        for (int r = 0; r < REPS; r++) begin
            for (int b = 1; b < 6; b++) begin
                step_issue($sformatf("opb sel %0d", b), ALU_ADD, OPA_IS_ZERO, opb_sel_e'(b),
                           rand_bits(32), rand_bits(32), rand_bits(32), ISSUE_ALU);
                step_idle();
            end
            for (int a = 1; a < 4; a++) begin
                step_issue($sformatf("opa sel %0d", a), ALU_ADD, opa_sel_e'(a), OPB_IS_RS2,
                           rand_bits(32), rand_bits(32), rand_bits(32), ISSUE_ALU);
                step_idle();
            end
        end
    endtask

    task automatic test_branches();
        xlen_t a;
        xlen_t b;
        inst_t inst;
        for (int k = 0; k < 7; k++) begin
            for (int p = 0; p < 4; p++) begin
                // Pairs are equal, less, signed less only and unsigned less only
                a = p == 2 ? 32'hfffffff0 : 32'd5;
                b = p == 0 ? 32'd5 : (p == 1 ? 32'd7 : (p == 2 ? 32'd3 : 32'hfffffff0));
                inst = rand_bits(32);
                inst[14:12] = k == 6 ? 3'd2 : (k < 2 ? 3'(k) : 3'(k + 2));  // 2 is undefined
                step_issue($sformatf("branch f3 %0d pair %0d", inst[14:12], p), ALU_ADD,
                           OPA_IS_PC, OPB_IS_B_IMM, inst, a, b, ISSUE_BRANCH);
                step_idle();
            end
        end
        for (int r = 0; r < REPS; r++) begin
            step_issue("jal", ALU_ADD, OPA_IS_PC, OPB_IS_J_IMM, rand_bits(32), rand_bits(32),
                       rand_bits(32), ISSUE_JAL);
            step_idle();
        end
    endtask

    task automatic test_memory();
        inst_t inst;
        for (int r = 0; r < REPS; r++) begin
            for (int k = 0; k < 8; k++) begin
                inst = rand_bits(32);
                inst[14:12] = k < 5 ? (k < 3 ? 3'(k) : 3'(k + 1)) : 3'(k - 5);
                if (k < 5) begin
                    step_issue($sformatf("load f3 %0d", inst[14:12]), ALU_ADD, OPA_IS_RS1,
                               OPB_IS_I_IMM, inst, rand_bits(32), rand_bits(32), ISSUE_LOAD);
                end else begin
                    step_issue($sformatf("store f3 %0d", inst[14:12]), ALU_ADD, OPA_IS_RS1,
                               OPB_IS_S_IMM, inst, rand_bits(32), rand_bits(32), ISSUE_STORE);
                end
                step_idle();
            end
        end
    endtask

    // One issue per cycle and each one checked on the cycle after
    task automatic test_back_to_back();
        step_issue("b2b xor", ALU_XOR, OPA_IS_RS1, OPB_IS_RS2, rand_bits(32), rand_bits(32),
                   rand_bits(32), ISSUE_ALU);
        step_issue("b2b load", ALU_ADD, OPA_IS_RS1, OPB_IS_I_IMM, rand_bits(32),
                   rand_bits(32), rand_bits(32), ISSUE_LOAD);
        step_issue("b2b store", ALU_ADD, OPA_IS_RS1, OPB_IS_S_IMM, rand_bits(32),
                   rand_bits(32), rand_bits(32), ISSUE_STORE);
        step_issue("b2b beq", ALU_ADD, OPA_IS_PC, OPB_IS_B_IMM,
                   rand_bits(32) & 32'hffff8fff, 32'd9, 32'd9, ISSUE_BRANCH);
        step_issue("b2b mulhu", ALU_MULHU, OPA_IS_RS1, OPB_IS_RS2, rand_bits(32),
                   rand_bits(32), rand_bits(32), ISSUE_ALU);
        step_idle();
        step_idle();
    endtask

    initial begin
        lfsr            = 32'd32134;
        errors          = 0;
        checks          = 0;
        exp_valid       = 4'b0000;
        exp_what        = "reset";
        rst_n           = 1'b0;
        issue_valid     = 1'b0;
        issue_inst      = '0;
        issue_pc        = '0;
        issue_opa_sel   = OPA_IS_RS1;
        issue_opb_sel   = OPB_IS_RS2;
        issue_func      = ALU_ADD;
        issue_rs1_value = '0;
        issue_rs2_value = '0;
        issue_rd_tag    = '0;
        {issue_cond_branch, issue_uncond_branch, issue_rd_mem, issue_wr_mem} = 4'b0000;
        repeat (RESET_CYCLES) @(negedge clock);
        check_pending();
        rst_n = 1'b1;
        test_alu_ops();
        test_multiply();
        test_operand_select();
        test_branches();
        test_memory();
        test_back_to_back();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * 20) @(posedge clock);
        $display("watchdog expired, tests did not finish within %0d cycles",
                 RESET_CYCLES + NUM_TESTS * 20);
        $display("sim failed");
        $finish;
    end

endmodule

// File: compile.f
logic/isa_pkg.sv
logic/ooo_pkg.sv
logic/issue_if.sv
logic/operand_select.sv
logic/alu.sv
logic/branch_cond.sv
logic/alu_exec_unit.sv
logic/agu_unit.sv
logic/exec_stage.sv
sim/tb_clock.sv
sim/exec_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the exec_stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module exec_stage_tb \
    --Mdir obj_dir -o exec_stage_sim > build.log 2>&1 \
    && ./obj_dir/exec_stage_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
